/* project.f */
source/zx_video_pkg.sv
source/sync_separator.sv
source/line_doubler.sv
source/tape_feedback.sv
source/scan_doubler_top.sv
sim/scan_checker.sv
sim/tb_scan_doubler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scan_doubler
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_scan_doubler.sv */
/*
 * scan doubler testbench
 * lfsr-driven zx81 line source and tape stimulus around the top level
 */
`timescale 1ns/1ps
`default_nettype none

module tb_scan_doubler;

	// one zx81 line spans two output lines
	localparam int line_len = 2 * zx_video_pkg::sd_line_len;
	localparam int hsync_len = 30;
	localparam int frame_sync_len = 120;
	localparam int lines_per_frame = 244;
	localparam int num_frames = 2;
	localparam int reset_cycles = 16;

	logic clk13 = 1'b0;
	logic rst;
	logic csync;
	logic video;
	logic tape_in;
	logic [5:0] vga_r;
	logic [5:0] vga_g;
	logic [5:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic audio_l;
	logic audio_r;
	logic led;

	int errors;
	int checks;

	// stimulus state
	logic [15:0] lfsr;
	logic tape_level;
	int tape_hold;
	logic timed_out;

	always #10 clk13 = !clk13;

	scan_doubler_top dut0 (
		.clk13 (clk13),
		.rst (rst),
		.csync (csync),
		.video (video),
		.tape_in (tape_in),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs),
		.audio_l (audio_l),
		.audio_r (audio_r),
		.led (led)
	);

	scan_checker u_checker (
		.clk13 (clk13),
		.rst (rst),
		.csync (csync),
		.video (video),
		.tape_in (tape_in),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs),
		.audio_l (audio_l),
		.audio_r (audio_r),
		.led (led),
		.errors (errors),
		.checks (checks)
	);

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// advance one clk13 cycle, tape toggles after a random hold
	task automatic next_cycle();
		logic [15:0] r;
		@(posedge clk13);
		if (tape_hold == 0) begin
			take_bits(9, r);
			tape_hold = 64 + int'(r);
			tape_level = !tape_level;
			tape_in <= tape_level;
		end else begin
			tape_hold = tape_hold - 1;
		end
	endtask

	// video part of a line, each zx81 pixel held two cycles
	task automatic drive_pixels(input int n);
		logic [15:0] r;
		for (int i = 0; i < n; i++) begin
			take_bits(1, r);
			next_cycle();
			csync <= 1'b1;
			video <= r[0];
			next_cycle();
		end
	endtask

	task automatic drive_line();
		for (int i = 0; i < hsync_len; i++) begin
			next_cycle();
			csync <= 1'b0;
			video <= 1'b0;
		end
		drive_pixels((line_len - hsync_len) / 2);
	endtask

	// long sync, the DUT must drop vga_vs before it ends
	task automatic drive_frame_sync();
		int waited;
		logic seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < frame_sync_len) begin
			next_cycle();
			csync <= 1'b0;
			video <= 1'b0;
			waited++;
			@(negedge clk13);
			if (vga_vs === 1'b0)
				seen = 1'b1;
		end
		if (!seen) begin
			$display("timeout: vga_vs stayed high for the whole %0d-cycle frame sync",
				frame_sync_len);
			timed_out = 1'b1;
		end else begin
			for (int i = waited; i < frame_sync_len; i++)
				next_cycle();
			drive_pixels((line_len - frame_sync_len) / 2);
		end
	endtask

	initial begin
		rst <= 1'b1;
		csync <= 1'b1;
		video <= 1'b0;
		tape_in <= 1'b0;
		lfsr = 16'd44490;
		tape_level = 1'b0;
		tape_hold = 100;
		timed_out = 1'b0;

		for (int i = 0; i < reset_cycles; i++)
			next_cycle();
		rst <= 1'b0;

		for (int f = 0; f < num_frames && !timed_out; f++) begin
			for (int l = 0; l < lines_per_frame; l++)
				drive_line();
			drive_frame_sync();
		end
		// a few lines into the next frame
		for (int l = 0; l < 20 && !timed_out; l++)
			drive_line();
		for (int i = 0; i < 8; i++)
			next_cycle();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (timed_out || errors != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/scan_checker.sv */
/*
 * scan doubler checker
 * rebuilds sync events, line buffer and tape path from the inputs
 * and compares every output on the falling clock edge
 */
`timescale 1ns/1ps
`default_nettype none

module scan_checker (
	input logic clk13,
	input logic rst,
	input logic csync,
	input logic video,
	input logic tape_in,
	input logic [5:0] vga_r,
	input logic [5:0] vga_g,
	input logic [5:0] vga_b,
	input logic vga_hs,
	input logic vga_vs,
	input logic audio_l,
	input logic audio_r,
	input logic led,
	output int errors,
	output int checks
);

	int err_cnt = 0;
	int check_cnt = 0;
	logic model_ready = 1'b0;

	// separator model
	logic cs_q;
	int low_cnt;
	logic in_short;
	logic vs_exp;
	logic ls;
	logic le;
	logic fs;

	// two-line copy of the sampled video
	logic line_bits [0:1][0:511];
	logic wr_half;
	logic [9:0] zx_col;
	logic [8:0] sd_col;
	logic [8:0] col_q;
	int line_cnt;
	logic pix;

	// tape model
	logic tape_meta;
	logic tape_sync;
	logic [7:0] pwm;

	assign errors = err_cnt;
	assign checks = check_cnt;

	task automatic compare(input string what, input logic [5:0] got, input logic [5:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// model steps on the same edge as the DUT
	always @(posedge clk13) begin
		if (rst) begin
			model_ready = 1'b1;
			cs_q = 1'b1;
			low_cnt = 0;
			in_short = 1'b0;
			vs_exp = 1'b0;
			ls = 1'b0;
			le = 1'b0;
			fs = 1'b0;
			wr_half = 1'b0;
			zx_col = '0;
			sd_col = '0;
			col_q = '0;
			line_cnt = 0;
			tape_meta = 1'b0;
			tape_sync = 1'b0;
			pwm = '0;
		end else begin
			// replay reads the half written during the previous line
			pix = line_bits[!wr_half][sd_col];
			// odd input columns carry the zx81 pixels
			if (zx_col[0])
				line_bits[wr_half][zx_col[9:1]] = video;
			col_q = sd_col;
			if (ls || int'(sd_col) == zx_video_pkg::sd_line_len - 1)
				sd_col = '0;
			else
				sd_col = sd_col + 9'd1;
			if (ls)
				zx_col = '0;
			else
				zx_col = zx_col + 10'd1;
			if (fs)
				line_cnt = 0;
			else if (le)
				line_cnt = line_cnt + 1;
			if (le)
				wr_half = !wr_half;

			// sync events, visible one cycle after the csync sample
			if (csync)
				low_cnt = 0;
			else if (low_cnt < zx_video_pkg::sync_len_max)
				low_cnt = low_cnt + 1;
			le = !csync && cs_q;
			ls = csync && !cs_q && in_short;
			fs = 1'b0;
			if (le) begin
				in_short = 1'b1;
				vs_exp = 1'b0;
			end else if (csync && !cs_q) begin
				in_short = 1'b0;
				vs_exp = 1'b0;
			end else if (!csync && in_short && low_cnt == zx_video_pkg::vsync_len) begin
				// long pulse, this is a vsync
				fs = 1'b1;
				in_short = 1'b0;
				vs_exp = 1'b1;
			end
			cs_q = csync;

			tape_sync = tape_meta;
			tape_meta = tape_in;
			pwm = pwm + 8'd1;
		end
	end

	always @(negedge clk13) begin
		logic pix_on;
		logic hs_exp;
		logic audio_exp;
		logic [5:0] grey;
		if (model_ready) begin
			// white for a 0 pixel inside both windows
			pix_on = int'(col_q) >= zx_video_pkg::h_de_start &&
				int'(col_q) < zx_video_pkg::h_de_end &&
				line_cnt >= zx_video_pkg::v_de_start &&
				line_cnt < zx_video_pkg::v_de_end && !pix;
			grey = {6{pix_on}};
			hs_exp = int'(col_q) < zx_video_pkg::hs_start;
			audio_exp = tape_sync && int'(pwm) < zx_video_pkg::audio_limit;
			compare("vga_r", vga_r, grey);
			compare("vga_g", vga_g, grey);
			compare("vga_b", vga_b, grey);
			compare("vga_hs", {5'b0, vga_hs}, {5'b0, hs_exp});
			compare("vga_vs", {5'b0, vga_vs}, {5'b0, !vs_exp});
			compare("audio_l", {5'b0, audio_l}, {5'b0, audio_exp});
			compare("audio_r", {5'b0, audio_r}, {5'b0, audio_exp});
			compare("led", {5'b0, led}, {5'b0, !tape_sync});
		end
	end

endmodule

`default_nettype wire

/* source/scan_doubler_top.sv */
/*
 * zx81 video and tape feedback top level
 * sync separator, line doubler and tape feedback on clk13
 */
`timescale 1ns/1ps
`default_nettype none

module scan_doubler_top (
	input logic clk13,
	input logic rst,
	input logic csync,
	input logic video,
	input logic tape_in,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic audio_l,
	output logic audio_r,
	output logic led
);

	// sync events from the separator
	logic line_start;
	logic line_end;
	logic frame_start;
	logic vsync;

	sync_separator u_sync_separator (
		.clk13 (clk13),
		.rst (rst),
		.csync (csync),
		.line_start (line_start),
		.line_end (line_end),
		.frame_start (frame_start),
		.vsync (vsync)
	);

	line_doubler u_line_doubler (
		.clk13 (clk13),
		.rst (rst),
		.video (video),
		.line_start (line_start),
		.line_end (line_end),
		.frame_start (frame_start),
		.vsync (vsync),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

	// tape path is independent of the video
	tape_feedback u_tape_feedback (
		.clk13 (clk13),
		.rst (rst),
		.tape_in (tape_in),
		.audio_l (audio_l),
		.audio_r (audio_r),
		.led (led)
	);

endmodule

`default_nettype wire

/* source/tape_feedback.sv */
/*
 * tape feedback
 * synchronizes the tape signal, drives the LED and a quiet PWM audio pulse
 */
`timescale 1ns/1ps
`default_nettype none

module tape_feedback (
	input logic clk13,
	input logic rst,
	input logic tape_in,
	output logic audio_l,
	output logic audio_r,
	output logic led
);

	// two-stage synchronizer for the asynchronous tape level
	logic tape_meta;
	logic tape_sync;
	// free-running pwm phase
	logic [zx_video_pkg::pwm_w-1:0] pwm_cnt;
	logic tape_audio;

	always_ff @(posedge clk13) begin
		if (rst) begin
			tape_meta <= 1'b0;
			tape_sync <= 1'b0;
			pwm_cnt <= '0;
		end else begin
			tape_meta <= tape_in;
			tape_sync <= tape_meta;
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// one eighth duty keeps the volume down
	assign tape_audio = tape_sync &&
		(pwm_cnt < zx_video_pkg::pwm_w'(zx_video_pkg::audio_limit));
	assign audio_l = tape_audio;
	assign audio_r = tape_audio;

	// video is distorted while loading, so the led shows tape activity
	assign led = !tape_sync;

endmodule

`default_nettype wire

/* source/line_doubler.sv */
/*
 * two-line scan doubler
 * stores one zx81 line at half rate while replaying the other twice,
 * then blanks, inverts and widens the pixel and makes the vga syncs
 */
`timescale 1ns/1ps
`default_nettype none

module line_doubler (
	input logic clk13,
	input logic rst,
	input logic video,
	input logic line_start,
	input logic line_end,
	input logic frame_start,
	input logic vsync,
	output logic [5:0] vga_r,
	output logic [5:0] vga_g,
	output logic [5:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	// two halves of 512 one-bit pixels, toggle picks the write half
	logic line_buf [0:(2**zx_video_pkg::zx_col_w)-1];
	logic toggle;

	// input column over a whole zx81 line
	logic [zx_video_pkg::zx_col_w-1:0] zx_col;
	// output column, restarts twice per input line
	logic [zx_video_pkg::sd_col_w-1:0] sd_col;
	// column delayed to match the registered pixel
	logic [zx_video_pkg::sd_col_w-1:0] sd_col_q;
	logic [zx_video_pkg::line_cnt_w-1:0] line_cnt;

	// pixel read from the replay half
	logic sd_video;

	logic h_de;
	logic v_de;
	logic hs;
	logic vb;

	// input side
	always_ff @(posedge clk13) begin
		if (rst) begin
			zx_col <= '0;
			toggle <= 1'b0;
			line_cnt <= '0;
		end else begin
			if (line_start)
				zx_col <= '0;
			else
				zx_col <= zx_col + 1'b1;

			// swap halves at the end of each zx81 line
			if (line_end)
				toggle <= !toggle;

			if (frame_start)
				line_cnt <= '0;
			else if (line_end)
				line_cnt <= line_cnt + 1'b1;
		end
	end

	// sample every second clk13 cycle, one pixel per zx81 pixel clock
	always_ff @(posedge clk13) begin
		if (zx_col[0])
			line_buf[{toggle, zx_col[zx_video_pkg::zx_col_w-1:1]}] <= video;
	end

	// output side
	always_ff @(posedge clk13) begin
		if (rst) begin
			sd_col <= '0;
			sd_col_q <= '0;
		end else begin
			if (line_start ||
					sd_col == zx_video_pkg::sd_col_w'(zx_video_pkg::sd_line_len - 1))
				sd_col <= '0;
			else
				sd_col <= sd_col + 1'b1;
			sd_col_q <= sd_col;
		end
	end

	// replay the other half at full rate
	always_ff @(posedge clk13) begin
		sd_video <= line_buf[{!toggle, sd_col}];
	end

	// display windows from the delayed column
	assign h_de = (sd_col_q >= zx_video_pkg::sd_col_w'(zx_video_pkg::h_de_start)) &&
		(sd_col_q < zx_video_pkg::sd_col_w'(zx_video_pkg::h_de_end));
	assign v_de = (line_cnt >= zx_video_pkg::line_cnt_w'(zx_video_pkg::v_de_start)) &&
		(line_cnt < zx_video_pkg::line_cnt_w'(zx_video_pkg::v_de_end));
	assign hs = (sd_col_q >= zx_video_pkg::sd_col_w'(zx_video_pkg::hs_start));

	// zx81 drives white for a 0 pixel
	assign vb = h_de && v_de && !sd_video;

	// grey, all channels the same
	assign vga_r = {6{vb}};
	assign vga_g = {6{vb}};
	assign vga_b = {6{vb}};

	// vga syncs are active low
	assign vga_hs = !hs;
	assign vga_vs = !vsync;

	a_sd_col_range: assert property (@(posedge clk13) disable iff (rst)
		sd_col <= zx_video_pkg::sd_col_w'(zx_video_pkg::sd_line_len - 1));

endmodule

`default_nettype wire

/* source/sync_separator.sv */
/*
 * composite sync separator
 * splits zx81 csync into line start, line end and vsync by pulse length
 */
`timescale 1ns/1ps
`default_nettype none

module sync_separator (
	input logic clk13,
	input logic rst,
	input logic csync,
	output logic line_start,
	output logic line_end,
	output logic frame_start,
	output logic vsync
);

	// previous csync sample for edge detection
	logic csync_d;
	// length of the current sync-low pulse
	logic [$clog2(zx_video_pkg::sync_len_max + 1)-1:0] sync_len;
	zx_video_pkg::sync_state_t state;

	logic cs_rise;
	logic cs_fall;

	assign cs_rise = csync && !csync_d;
	assign cs_fall = !csync && csync_d;

	always_ff @(posedge clk13) begin
		if (rst) begin
			csync_d <= 1'b1;
			sync_len <= '0;
			state <= zx_video_pkg::sep_video;
			line_start <= 1'b0;
			line_end <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			csync_d <= csync;
			line_start <= 1'b0;
			line_end <= 1'b0;
			frame_start <= 1'b0;

			// count sync-low cycles up to sync_len_max
			if (csync)
				sync_len <= '0;
			else if (sync_len < ($bits(sync_len))'(zx_video_pkg::sync_len_max))
				sync_len <= sync_len + 1'b1;

			if (cs_fall) begin
				state <= zx_video_pkg::sep_hsync;
				line_end <= 1'b1;
			end else if (cs_rise) begin
				// only a short pulse restarts the line
				state <= zx_video_pkg::sep_video;
				line_start <= (state == zx_video_pkg::sep_hsync);
			end else if (!csync && state == zx_video_pkg::sep_hsync &&
					sync_len == ($bits(sync_len))'(zx_video_pkg::vsync_len - 1)) begin
				// counter hits vsync_len on this edge
				state <= zx_video_pkg::sep_vsync;
				frame_start <= 1'b1;
			end
		end
	end

	// vsync level follows the long-pulse state
	assign vsync = (state == zx_video_pkg::sep_vsync);

	a_start_excl: assert property (@(posedge clk13) disable iff (rst)
		!(line_start && frame_start));

	a_frame_in_sync: assert property (@(posedge clk13) disable iff (rst)
		frame_start |-> !csync);

endmodule

`default_nettype wire

/* source/zx_video_pkg.sv */
/*
 * ZX81 scan doubler shared definitions
 * line and frame geometry, sync thresholds, audio limit and separator states
 */
`default_nettype none

package zx_video_pkg;

	// output line, one zx81 line at 828 clk13 cycles split in two
	localparam int sd_line_len = 414;
	localparam int sd_col_w = 9;

	// input column counts a whole zx81 line at clk13 rate
	localparam int zx_col_w = 10;

	// sync pulses longer than this are a vsync
	localparam int vsync_len = 80;
	// sync length counter stops here
	localparam int sync_len_max = 255;

	// horizontal display window, 16 border pixels each side
	localparam int h_de_start = 64;
	localparam int h_de_end = 352;
	// hsync from here to the end of the output line
	localparam int hs_start = 384;

	// vertical display window in input lines
	localparam int v_de_start = 16;
	localparam int v_de_end = 240;
	localparam int line_cnt_w = 10;

	// pwm threshold, 32 of 256 is one eighth volume
	localparam int audio_limit = 32;
	localparam int pwm_w = 8;

	// composite sync separator states
	typedef enum logic [1:0] {
		sep_video,
		sep_hsync,
		sep_vsync
	} sync_state_t;

endpackage

`default_nettype wire
